/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

  parameter int AXI_ADDR_W = 16;
  parameter int AXI_DATA_W = 32;
  parameter int AXI_ID_W = 4;
  parameter int AXI_LEN_W = 8;
  parameter int AXI_SIZE_W = 3;
  parameter int AXI_STRB_W = AXI_DATA_W / 8;
  // byte offset bits inside one data word
  parameter int AXI_ADDR_LSB = $clog2(AXI_STRB_W);

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  parameter logic [1:0] AXI_RESP_OKAY = 2'b00;

  // one AW or AR command
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_SIZE_W-1:0] size;
    axi_burst_e            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

endpackage

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  parameter int MEM_DATA_W = 32;
  // word address of which sram uses the low bits it needs
  parameter int MEM_ADDR_W = 14;
  parameter int MEM_BE_W = MEM_DATA_W / 8;

  typedef struct packed {
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_DATA_W-1:0] data;
    logic [MEM_BE_W-1:0]   be;
  } mem_wr_req_t;

  typedef struct packed {
    logic                  re;
    logic [MEM_ADDR_W-1:0] addr;
  } mem_rd_req_t;

endpackage

`default_nettype wire

/* axi_skid_buffer.sv */
`default_nettype none

module axi_skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_ready,
  output logic             o_ready,
  output logic             o_valid,
  output logic [WIDTH-1:0] o_data
);

  logic             ready_q;
  logic             skid_valid_q;
  logic [WIDTH-1:0] skid_data_q;

  // beat taken upstream but refused downstream goes to the skid register
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ready_q      <= 1'b1;
      skid_valid_q <= 1'b0;
    end else if (i_valid && ready_q && !i_ready) begin
      ready_q      <= 1'b0;
      skid_valid_q <= 1'b1;
    end else if (i_ready) begin
      ready_q      <= 1'b1;
      skid_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_q) begin
      skid_data_q <= i_data;
    end
  end

  // empty buffer passes straight through
  assign o_ready = ready_q;
  assign o_valid = i_valid || skid_valid_q;
  assign o_data  = skid_valid_q ? skid_data_q : i_data;

endmodule

`default_nettype wire

/* axi_burst_addr.sv */
`default_nettype none

module axi_burst_addr
  import axi_pkg::*;
(
  input  logic [AXI_ADDR_W-1:0] i_addr,
  input  logic [AXI_LEN_W-1:0]  i_len,
  input  logic [AXI_SIZE_W-1:0] i_size,
  input  axi_burst_e            i_burst,
  output logic [AXI_ADDR_W-1:0] o_next_addr
);

  logic [AXI_ADDR_W-1:0] beat_bytes;
  logic [AXI_ADDR_W-1:0] incr_addr;
  logic [AXI_ADDR_W-1:0] wrap_size;
  logic [AXI_ADDR_W-1:0] wrap_mask;

  assign beat_bytes = AXI_ADDR_W'(1) << i_size;
  assign incr_addr  = i_addr + beat_bytes;

  // window of beat size times beat count is a power of two for legal wraps
  assign wrap_size = (AXI_ADDR_W'(i_len) + AXI_ADDR_W'(1)) << i_size;
  assign wrap_mask = wrap_size - AXI_ADDR_W'(1);

  always_comb begin
    case (i_burst)
      FIXED:   o_next_addr = i_addr;
      WRAP:    o_next_addr = (i_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default: o_next_addr = incr_addr;
    endcase
  end

endmodule

`default_nettype wire

/* axi_slave_write.sv */
`default_nettype none

module axi_slave_write
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        i_aw_valid,
  input  axi_ax_t     i_aw,
  input  logic        i_w_valid,
  input  axi_w_t      i_w,
  input  logic        i_b_ready,
  output logic        o_aw_ready,
  output logic        o_w_ready,
  output logic        o_b_valid,
  output axi_b_t      o_b,
  output mem_wr_req_t o_mem_wr
);

  logic                  aw_ready_q;
  logic                  w_ready_q;
  logic                  b_valid_q;
  logic                  b_pend_q;
  logic [AXI_ID_W-1:0]   b_id_q;
  axi_ax_t               cmd_q;
  logic [AXI_ADDR_W-1:0] next_addr;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  last_fire;
  logic                  b_free;

  assign aw_fire   = i_aw_valid && o_aw_ready;
  assign w_fire    = i_w_valid && w_ready_q;
  assign last_fire = w_fire && i_w.last;
  assign b_free    = !b_valid_q || i_b_ready;

  // reopen aw on the last beat if the b slot frees up
  assign o_aw_ready = aw_ready_q || (last_fire && b_free);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      aw_ready_q <= 1'b1;
      w_ready_q  <= 1'b0;
    end else if (aw_fire) begin
      aw_ready_q <= 1'b0;
      w_ready_q  <= 1'b1;
    end else if (w_fire) begin
      aw_ready_q <= i_w.last && b_free;
      w_ready_q  <= !i_w.last;
    end else if (!aw_ready_q && !w_ready_q) begin
      // wait for the held response to drain
      aw_ready_q <= !(b_pend_q && !i_b_ready);
    end
  end

  axi_burst_addr u_next_addr (
    .i_addr      (cmd_q.addr),
    .i_len       (cmd_q.len),
    .i_size      (cmd_q.size),
    .i_burst     (cmd_q.burst),
    .o_next_addr (next_addr)
  );

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      cmd_q <= i_aw;
    end else if (w_fire) begin
      cmd_q.addr <= next_addr;
    end
  end

  // second completed burst while b is stalled
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      b_pend_q <= 1'b0;
    end else if (last_fire && !b_free) begin
      b_pend_q <= 1'b1;
    end else if (i_b_ready) begin
      b_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
    end else if (last_fire) begin
      b_valid_q <= 1'b1;
    end else if (i_b_ready) begin
      b_valid_q <= b_pend_q;
    end
  end

  // cmd id still belongs to the finished burst here
  always_ff @(posedge clk_i) begin
    if (b_free) begin
      b_id_q <= cmd_q.id;
    end
  end

  assign o_w_ready = w_ready_q;
  assign o_b_valid = b_valid_q;
  assign o_b.id    = b_id_q;
  assign o_b.resp  = AXI_RESP_OKAY;

  assign o_mem_wr.we   = w_fire;
  assign o_mem_wr.addr = cmd_q.addr[AXI_ADDR_W-1:AXI_ADDR_LSB];
  assign o_mem_wr.data = i_w.data;
  assign o_mem_wr.be   = i_w.strb;

endmodule

`default_nettype wire

/* axi_slave_read.sv */
`default_nettype none

module axi_slave_read
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  i_ar_valid,
  input  axi_ax_t               i_ar,
  input  logic                  i_r_ready,
  input  logic [MEM_DATA_W-1:0] i_mem_rdata,
  output logic                  o_ar_ready,
  output logic                  o_r_valid,
  output axi_r_t                o_r,
  output mem_rd_req_t           o_mem_rd
);

  axi_ax_t               cmd_q;
  axi_ax_t               cur_cmd;
  logic [AXI_LEN_W-1:0]  left_q;
  logic [AXI_LEN_W-1:0]  beats_left;
  logic [AXI_ADDR_W-1:0] next_addr;
  logic                  r_valid_q;
  logic [AXI_ID_W-1:0]   r_id_q;
  logic                  r_last_q;
  logic                  busy;
  logic                  issue_ok;
  logic                  ar_fire;
  logic                  issue;

  // reads still to issue for the current burst
  assign busy = (left_q != '0);

  // sram output is the r data, so only read when it is free or draining
  assign issue_ok = !r_valid_q || i_r_ready;

  assign o_ar_ready = !busy && issue_ok;
  assign ar_fire    = i_ar_valid && o_ar_ready;
  assign issue      = ar_fire || (busy && issue_ok);

  // a new command is read in its handshake cycle
  assign cur_cmd    = ar_fire ? i_ar : cmd_q;
  assign beats_left = ar_fire ? i_ar.len : left_q - AXI_LEN_W'(1);

  axi_burst_addr u_next_addr (
    .i_addr      (cur_cmd.addr),
    .i_len       (cur_cmd.len),
    .i_size      (cur_cmd.size),
    .i_burst     (cur_cmd.burst),
    .o_next_addr (next_addr)
  );

  always_ff @(posedge clk_i) begin
    if (issue) begin
      cmd_q      <= cur_cmd;
      cmd_q.addr <= next_addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      left_q <= '0;
    end else if (issue) begin
      left_q <= beats_left;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (issue) begin
      r_valid_q <= 1'b1;
    end else if (i_r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // tags follow the data through the sram latency
  always_ff @(posedge clk_i) begin
    if (issue) begin
      r_id_q   <= cur_cmd.id;
      r_last_q <= (beats_left == '0);
    end
  end

  assign o_mem_rd.re   = issue;
  assign o_mem_rd.addr = cur_cmd.addr[AXI_ADDR_W-1:AXI_ADDR_LSB];

  assign o_r_valid = r_valid_q;
  assign o_r.id    = r_id_q;
  assign o_r.data  = i_mem_rdata;
  assign o_r.resp  = AXI_RESP_OKAY;
  assign o_r.last  = r_last_q;

endmodule

`default_nettype wire

/* sram_core.sv */
`default_nettype none

module sram_core
  import mem_pkg::*;
#(
  parameter int MEM_DEPTH = 1024
) (
  input  logic                  clk_i,
  input  mem_wr_req_t           i_wr,
  input  mem_rd_req_t           i_rd,
  output logic [MEM_DATA_W-1:0] o_rdata
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  logic [MEM_DATA_W-1:0] mem_q [MEM_DEPTH];

  always_ff @(posedge clk_i) begin
    if (i_wr.we) begin
      for (int b = 0; b < MEM_BE_W; b++) begin
        if (i_wr.be[b]) begin
          mem_q[i_wr.addr[IDX_W-1:0]][b*8 +: 8] <= i_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // same-word collision returns the old word
  always_ff @(posedge clk_i) begin
    if (i_rd.re) begin
      o_rdata <= mem_q[i_rd.addr[IDX_W-1:0]];
    end
  end

endmodule

`default_nettype wire

/* axi_mem_top.sv */
`default_nettype none

module axi_mem_top
  import axi_pkg::*;
  import mem_pkg::*;
#(
  parameter int MEM_DEPTH = 1024
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    i_aw_valid,
  input  axi_ax_t i_aw,
  input  logic    i_w_valid,
  input  axi_w_t  i_w,
  input  logic    i_b_ready,
  input  logic    i_ar_valid,
  input  axi_ax_t i_ar,
  input  logic    i_r_ready,
  output logic    o_aw_ready,
  output logic    o_w_ready,
  output logic    o_b_valid,
  output axi_b_t  o_b,
  output logic    o_ar_ready,
  output logic    o_r_valid,
  output axi_r_t  o_r
);

  localparam int AX_W = $bits(axi_ax_t);

  logic                  aw_valid;
  logic                  aw_ready;
  axi_ax_t               aw_cmd;
  logic                  ar_valid;
  logic                  ar_ready;
  axi_ax_t               ar_cmd;
  mem_wr_req_t           mem_wr;
  mem_rd_req_t           mem_rd;
  logic [MEM_DATA_W-1:0] mem_rdata;

  axi_skid_buffer #(
    .WIDTH (AX_W)
  ) u_aw_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .i_valid (i_aw_valid),
    .i_data  (i_aw),
    .i_ready (aw_ready),
    .o_ready (o_aw_ready),
    .o_valid (aw_valid),
    .o_data  (aw_cmd)
  );

  axi_skid_buffer #(
    .WIDTH (AX_W)
  ) u_ar_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .i_valid (i_ar_valid),
    .i_data  (i_ar),
    .i_ready (ar_ready),
    .o_ready (o_ar_ready),
    .o_valid (ar_valid),
    .o_data  (ar_cmd)
  );

  axi_slave_write u_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_aw_valid (aw_valid),
    .i_aw       (aw_cmd),
    .i_w_valid  (i_w_valid),
    .i_w        (i_w),
    .i_b_ready  (i_b_ready),
    .o_aw_ready (aw_ready),
    .o_w_ready  (o_w_ready),
    .o_b_valid  (o_b_valid),
    .o_b        (o_b),
    .o_mem_wr   (mem_wr)
  );

  axi_slave_read u_read (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_ar_valid  (ar_valid),
    .i_ar        (ar_cmd),
    .i_r_ready   (i_r_ready),
    .i_mem_rdata (mem_rdata),
    .o_ar_ready  (ar_ready),
    .o_r_valid   (o_r_valid),
    .o_r         (o_r),
    .o_mem_rd    (mem_rd)
  );

  sram_core #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_sram (
    .clk_i   (clk_i),
    .i_wr    (mem_wr),
    .i_rd    (mem_rd),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`default_nettype none

module tb_axi_mem
  import axi_pkg::*;
();

  localparam int PERIOD = 100;
  localparam int DRV = 10;
  localparam int TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'h7176_0c10;

  typedef struct {
    string                 name;
    bit                    write;
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_SIZE_W-1:0] size;
    axi_burst_e            burst;
    logic [AXI_DATA_W-1:0] seed;
    logic [AXI_STRB_W-1:0] strb;
    bit                    stall;
  } row_t;

  logic    clk_i;
  logic    rst_ni;
  logic    aw_valid;
  axi_ax_t aw_cmd;
  logic    aw_ready;
  logic    w_valid;
  axi_w_t  w_beat;
  logic    w_ready;
  logic    b_valid;
  axi_b_t  b_resp;
  logic    b_ready;
  logic    ar_valid;
  axi_ax_t ar_cmd;
  logic    ar_ready;
  logic    r_valid;
  axi_r_t  r_beat;
  logic    r_ready;

  row_t                  rows[$];
  logic [31:0]           ref_mem[int];
  logic [AXI_ID_W-1:0]   b_exp_id[$];
  string                 b_exp_name[$];
  logic [AXI_DATA_W-1:0] r_exp_data[$];
  logic [AXI_ID_W-1:0]   r_exp_id[$];
  logic                  r_exp_last[$];
  string                 b_name;
  string                 rd_name;
  logic                  stall_on;

  axi_mem_top #(
    .MEM_DEPTH (1024)
  ) uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_aw_valid (aw_valid),
    .i_aw       (aw_cmd),
    .i_w_valid  (w_valid),
    .i_w        (w_beat),
    .i_b_ready  (b_ready),
    .i_ar_valid (ar_valid),
    .i_ar       (ar_cmd),
    .i_r_ready  (r_ready),
    .o_aw_ready (aw_ready),
    .o_w_ready  (w_ready),
    .o_b_valid  (b_valid),
    .o_b        (b_resp),
    .o_ar_ready (ar_ready),
    .o_r_valid  (r_valid),
    .o_r        (r_beat)
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("CHECKS FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      abort_run($sformatf("%s does not match", name));
    end
  endtask

  task automatic add_row(input string name, input bit write, input int id, input int addr,
                         input int len, input int size, input axi_burst_e burst,
                         input int seed, input int strb, input bit stall);
    row_t row;
    row.name  = name;
    row.write = write;
    row.id    = AXI_ID_W'(id);
    row.addr  = AXI_ADDR_W'(addr);
    row.len   = AXI_LEN_W'(len);
    row.size  = AXI_SIZE_W'(size);
    row.burst = burst;
    row.seed  = AXI_DATA_W'(seed);
    row.strb  = AXI_STRB_W'(strb);
    row.stall = stall;
    rows.push_back(row);
  endtask

  // next beat address by the AXI burst rules
  function automatic logic [AXI_ADDR_W-1:0] beat_addr(input logic [AXI_ADDR_W-1:0] addr,
      input logic [AXI_LEN_W-1:0] len, input logic [AXI_SIZE_W-1:0] size,
      input axi_burst_e burst);
    int bytes;
    int window;
    int base;
    int nxt;
    bytes  = 1 << size;
    window = (int'(len) + 1) * bytes;
    base   = (int'(addr) / window) * window;
    nxt    = int'(addr) + bytes;
    if (burst == FIXED) begin
      nxt = int'(addr);
    end else if (burst == WRAP && nxt >= base + window) begin
      nxt = base;
    end
    return AXI_ADDR_W'(nxt);
  endfunction

  function automatic logic [AXI_DATA_W-1:0] beat_data(input logic [AXI_DATA_W-1:0] seed,
                                                      input int beat);
    return seed + 32'(beat) * 32'h0101_0101;
  endfunction

  task automatic model_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data,
                             input logic [AXI_STRB_W-1:0] strb);
    int          word;
    logic [31:0] old;
    word = int'(addr) >> 2;
    old  = ref_mem.exists(word) ? ref_mem[word] : 32'hx;
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (strb[b]) begin
        old[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    ref_mem[word] = old;
  endtask

  // holds valid until ready is seen on a clock edge
  task automatic handshake(input string chan);
    int   n;
    logic rdy;
    n   = 0;
    rdy = 1'b0;
    while (!rdy) begin
      @(posedge clk_i);
      if (chan == "AW") begin
        rdy = aw_ready;
      end else if (chan == "W") begin
        rdy = w_ready;
      end else begin
        rdy = ar_ready;
      end
      #DRV;
      n++;
      if (!rdy && n >= TIMEOUT) begin
        abort_run($sformatf("timeout, %s ready never came", chan));
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (b_exp_id.size() != 0 || r_exp_data.size() != 0) begin
      @(posedge clk_i);
      #DRV;
      n++;
      if (n >= TIMEOUT) begin
        abort_run("timeout, B or R responses still outstanding");
      end
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = $urandom_range(0, 2);
    repeat (gap) begin
      @(posedge clk_i);
      #DRV;
    end
  endtask

  task automatic write_burst(input row_t row);
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
    addr = row.addr;
    b_exp_id.push_back(row.id);
    b_exp_name.push_back(row.name);
    aw_cmd   = '{id: row.id, addr: row.addr, len: row.len, size: row.size, burst: row.burst};
    aw_valid = 1'b1;
    handshake("AW");
    aw_valid = 1'b0;
    for (int beat = 0; beat <= int'(row.len); beat++) begin
      if (row.stall) begin
        idle_gap();
      end
      data    = beat_data(row.seed, beat);
      w_beat  = '{data: data, strb: row.strb, last: (beat == int'(row.len))};
      w_valid = 1'b1;
      handshake("W");
      w_valid = 1'b0;
      model_write(addr, data, row.strb);
      addr = beat_addr(addr, row.len, row.size, row.burst);
    end
  endtask

  task automatic read_burst(input row_t row);
    logic [AXI_ADDR_W-1:0] addr;
    int                    word;
    // writes must have landed before the model is read
    wait_idle();
    rd_name = row.name;
    addr    = row.addr;
    for (int beat = 0; beat <= int'(row.len); beat++) begin
      word = int'(addr) >> 2;
      if (!ref_mem.exists(word) || $isunknown(ref_mem[word])) begin
        abort_run($sformatf("%s reads bytes that were never written", row.name));
      end
      r_exp_data.push_back(ref_mem[word]);
      r_exp_id.push_back(row.id);
      r_exp_last.push_back(beat == int'(row.len));
      addr = beat_addr(addr, row.len, row.size, row.burst);
    end
    ar_cmd   = '{id: row.id, addr: row.addr, len: row.len, size: row.size, burst: row.burst};
    ar_valid = 1'b1;
    handshake("AR");
    ar_valid = 1'b0;
    wait_idle();
  endtask

  // B channel monitor
  always @(posedge clk_i) begin
    if (rst_ni && b_valid && b_ready) begin
      if (b_exp_id.size() == 0) begin
        abort_run("B response arrived with no write outstanding");
      end else begin
        b_name = b_exp_name.pop_front();
        compare({b_name, " bid"}, 64'(b_exp_id.pop_front()), 64'(b_resp.id));
        compare({b_name, " bresp"}, 64'(AXI_RESP_OKAY), 64'(b_resp.resp));
      end
    end
    #DRV;
    b_ready = rst_ni && (!stall_on || ($urandom_range(0, 3) == 0));
  end

  // R channel monitor
  always @(posedge clk_i) begin
    if (rst_ni && r_valid && r_ready) begin
      if (r_exp_data.size() == 0) begin
        abort_run("R beat arrived with no read beat outstanding");
      end else begin
        compare({rd_name, " rdata"}, 64'(r_exp_data.pop_front()), 64'(r_beat.data));
        compare({rd_name, " rid"}, 64'(r_exp_id.pop_front()), 64'(r_beat.id));
        compare({rd_name, " rlast"}, 64'(r_exp_last.pop_front()), 64'(r_beat.last));
        compare({rd_name, " rresp"}, 64'(AXI_RESP_OKAY), 64'(r_beat.resp));
      end
    end
    #DRV;
    r_ready = rst_ni && (!stall_on || ($urandom_range(0, 1) == 0));
  end

  initial begin
    void'($urandom(SEED));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    aw_valid = 1'b0;
    aw_cmd   = '0;
    w_valid  = 1'b0;
    w_beat   = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar_cmd   = '0;
    r_ready  = 1'b0;
    stall_on = 1'b0;

    // name, write, id, addr, len, size, burst, data seed, strobes, stall
    add_row("single_wr", 1, 3, 'h0010, 0, 2, INCR, 'ha5a5_0001, 'hf, 0);
    add_row("single_rd", 0, 5, 'h0010, 0, 2, INCR, 0, 0, 0);
    add_row("incr_wr", 1, 1, 'h0100, 7, 2, INCR, 'h1000_0000, 'hf, 0);
    add_row("incr_rd", 0, 2, 'h0100, 7, 2, INCR, 0, 0, 0);
    // starts mid-window in 0x200..0x20f
    add_row("wrap_wr", 1, 6, 'h0208, 3, 2, WRAP, 'h2000_0000, 'hf, 0);
    add_row("fixed_wr", 1, 7, 'h0300, 3, 2, FIXED, 'h3000_0000, 'hf, 0);
    add_row("wrap_rd", 0, 8, 'h0200, 3, 2, INCR, 0, 0, 0);
    add_row("fixed_rd", 0, 9, 'h0300, 0, 2, INCR, 0, 0, 0);
    add_row("strb_wr", 1, 10, 'h0100, 3, 2, INCR, 'h4444_4444, 'h5, 0);
    add_row("strb_rd", 0, 11, 'h0100, 7, 2, INCR, 0, 0, 0);
    add_row("bp_wr_a", 1, 12, 'h0400, 7, 2, INCR, 'h5000_0000, 'hf, 1);
    add_row("bp_wr_b", 1, 13, 'h0480, 1, 2, INCR, 'h6000_0000, 'hf, 1);
    add_row("bp_wr_c", 1, 14, 'h0408, 7, 2, WRAP, 'h7000_0000, 'he, 1);
    add_row("bp_rd_a", 0, 15, 'h0400, 7, 2, INCR, 0, 0, 1);
    add_row("bp_rd_b", 0, 0, 'h0480, 1, 2, INCR, 0, 0, 1);

    repeat (2) @(posedge clk_i);
    #DRV;
    rst_ni <= 1'b1;

    @(posedge clk_i);
    compare("reset bvalid", 64'd0, 64'(b_valid));
    compare("reset rvalid", 64'd0, 64'(r_valid));
    compare("reset wready", 64'd0, 64'(w_ready));
    compare("reset awready", 64'd1, 64'(aw_ready));
    compare("reset arready", 64'd1, 64'(ar_ready));
    #DRV;

    foreach (rows[i]) begin
      stall_on <= rows[i].stall;
      if (rows[i].write) begin
        write_burst(rows[i]);
      end else begin
        read_burst(rows[i]);
      end
    end

    stall_on <= 1'b0;
    wait_idle();
    // late extra responses would still show up here
    repeat (4) begin
      @(posedge clk_i);
      #DRV;
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
axi_pkg.sv
mem_pkg.sv
axi_skid_buffer.sv
axi_burst_addr.sv
axi_slave_write.sv
axi_slave_read.sv
sram_core.sv
axi_mem_top.sv
tb_axi_mem.sv

/* Makefile */
TOP = tb_axi_mem

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
